/* src.f */
source/icache_cfg_pkg.sv
source/icache_msg_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_lru.sv
source/icache_fetch_pipe.sv
source/icache_top.sv
tb/icache_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)_sim
	@out=$$(./obj_dir/$(TOP)_sim); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* tb/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
();

  localparam int wait_limit   = 64;
  localparam int stream_limit = 20000;

  logic      clk_i;
  logic      reset_i;
  logic      fetch_v_i;
  addr_t     fetch_addr_i;
  logic      fetch_yumi_o;
  instr_t    data_o;
  logic      data_v_o;
  logic      data_yumi_i;
  miss_req_s miss_o;
  logic      miss_v_o;
  logic      miss_yumi_i;
  logic      fill_v_i;
  fill_pkt_s fill_i;
  logic      fill_yumi_o;

  // Requests waiting to be issued, and requests inside the cache
  addr_t pending_q[$];
  addr_t outstanding_q[$];
  int    miss_seen;

  icache_top DUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fetch_v_i    (fetch_v_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_yumi_o (fetch_yumi_o),
    .data_o       (data_o),
    .data_v_o     (data_v_o),
    .data_yumi_i  (data_yumi_i),
    .miss_o       (miss_o),
    .miss_v_o     (miss_v_o),
    .miss_yumi_i  (miss_yumi_i),
    .fill_v_i     (fill_v_i),
    .fill_i       (fill_i),
    .fill_yumi_o  (fill_yumi_o)
  );

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Backing memory model
  ////////////////////////////////////////

  function automatic instr_t model_word(input addr_t a);
    return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic addr_t block_base(input addr_t a);
    return {a[31:3], 3'b000};
  endfunction

  // Tag from bits 31 to 7, index from bits 6 to 3, word 0 in the low half
  function automatic fill_pkt_s make_fill(input miss_req_s req);
    fill_pkt_s pkt;
    pkt.index = req.addr[6:3];
    pkt.way   = req.repl_way;
    pkt.tag   = req.addr[31:7];
    pkt.data  = {model_word(req.addr + 32'd4), model_word(req.addr)};
    return pkt;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  ////////////////////////////////////////
  // Single request helpers
  ////////////////////////////////////////

  // All helpers start and end 1 ns after a rising edge
  task automatic send_fetch(input addr_t a);
    int waited;
    waited       = 0;
    fetch_v_i    = 1'b1;
    fetch_addr_i = a;
    #1;
    while (!fetch_yumi_o)
    begin
      waited++;
      assert (waited < wait_limit)
        else stop_with_error($sformatf("fetch of %h was not accepted in time", a));
      @(posedge clk_i);
      #2;
    end
    @(posedge clk_i);
    #1;
    fetch_v_i = 1'b0;
  endtask

  task automatic wait_response(output logic is_hit, output instr_t word,
                               output miss_req_s req);
    int waited;
    waited = 0;
    #1;
    while (!(data_v_o || miss_v_o))
    begin
      waited++;
      assert (waited < wait_limit)
        else stop_with_error("no data or miss came back in time");
      @(posedge clk_i);
      #2;
    end
    is_hit = data_v_o;
    word   = data_o;
    req    = miss_o;
    @(posedge clk_i);
    #1;
    data_yumi_i = is_hit;
    miss_yumi_i = !is_hit;
    @(posedge clk_i);
    #1;
    data_yumi_i = 1'b0;
    miss_yumi_i = 1'b0;
  endtask

  task automatic send_fill(input fill_pkt_s pkt);
    int waited;
    waited   = 0;
    fill_v_i = 1'b1;
    fill_i   = pkt;
    #1;
    while (!fill_yumi_o)
    begin
      waited++;
      assert (waited < wait_limit)
        else stop_with_error("fill was not accepted in time");
      @(posedge clk_i);
      #2;
    end
    @(posedge clk_i);
    #1;
    fill_v_i = 1'b0;
  endtask

  task automatic expect_hit(input addr_t a);
    logic      is_hit;
    instr_t    word;
    miss_req_s req;
    send_fetch(a);
    wait_response(is_hit, word, req);
    assert (is_hit)
      else stop_with_error($sformatf("fetch of %h missed where a hit was expected", a));
    assert (word == model_word(a))
      else stop_with_error($sformatf("Fail data_o: got %h, expected %h", word, model_word(a)));
  endtask

  // Miss, fill from the model, then the re-issued fetch must hit
  task automatic expect_miss_fill(input addr_t a, input way_t exp_way);
    logic      is_hit;
    instr_t    word;
    miss_req_s req;
    send_fetch(a);
    wait_response(is_hit, word, req);
    assert (!is_hit)
      else stop_with_error($sformatf("fetch of %h hit where a miss was expected", a));
    assert (req.addr == block_base(a))
      else stop_with_error($sformatf("Fail miss_o.addr: got %h, expected %h",
                                     req.addr, block_base(a)));
    assert (req.repl_way == exp_way)
      else stop_with_error($sformatf("Fail miss_o.repl_way: got %h, expected %h",
                                     req.repl_way, exp_way));
    send_fill(make_fill(req));
    expect_hit(a);
  endtask

  ////////////////////////////////////////
  // Streaming driver
  ////////////////////////////////////////

  // Responses after a miss are dropped and those fetches issued again
  task automatic stream_fetches(input int max_hold);
    int        cycles;
    int        hold_left;
    int        drop_count;
    logic      fill_pending;
    logic      held_last;
    instr_t    held_data;
    fill_pkt_s fill_pkt;
    addr_t     head;
    cycles       = 0;
    hold_left    = $urandom_range(max_hold, 0);
    drop_count   = 0;
    fill_pending = 1'b0;
    held_last    = 1'b0;
    held_data    = '0;
    fill_pkt     = '0;
    while (pending_q.size() > 0 || outstanding_q.size() > 0 || drop_count > 0 || fill_pending)
    begin
      cycles++;
      assert (cycles < stream_limit)
        else stop_with_error("fetch stream did not finish in time");
      if (held_last)
      begin
        assert (data_o == held_data)
          else stop_with_error($sformatf("Fail data_o: got %h, expected %h under back-pressure",
                                         data_o, held_data));
      end
      fetch_v_i = (pending_q.size() > 0);
      if (pending_q.size() > 0)
      begin
        fetch_addr_i = pending_q[0];
      end
      data_yumi_i = data_v_o && (hold_left == 0);
      miss_yumi_i = miss_v_o;
      fill_v_i    = fill_pending;
      fill_i      = fill_pkt;
      #1;
      held_last = data_v_o && !data_yumi_i;
      held_data = data_o;
      if (held_last)
      begin
        hold_left--;
      end
      if (fill_yumi_o)
      begin
        fill_pending = 1'b0;
      end
      if (fetch_yumi_o)
      begin
        outstanding_q.push_back(pending_q.pop_front());
      end
      if (data_v_o && data_yumi_i)
      begin
        hold_left = $urandom_range(max_hold, 0);
        if (drop_count > 0)
        begin
          drop_count--;
        end
        else
        begin
          assert (outstanding_q.size() > 0)
            else stop_with_error("data came back with no fetch outstanding");
          head = outstanding_q.pop_front();
          assert (data_o == model_word(head))
            else stop_with_error($sformatf("Fail data_o: got %h, expected %h",
                                           data_o, model_word(head)));
        end
      end
      if (miss_v_o && miss_yumi_i)
      begin
        miss_seen++;
        fill_pkt     = make_fill(miss_o);
        fill_pending = 1'b1;
        if (drop_count > 0)
        begin
          drop_count--;
        end
        else
        begin
          head = outstanding_q[0];
          assert (miss_o.addr == block_base(head))
            else stop_with_error($sformatf("Fail miss_o.addr: got %h, expected %h",
                                           miss_o.addr, block_base(head)));
          drop_count = outstanding_q.size() - 1;
          while (outstanding_q.size() > 0)
          begin
            pending_q.push_front(outstanding_q.pop_back());
          end
        end
      end
      assert (outstanding_q.size() + drop_count <= 2)
        else stop_with_error("more than two fetches were accepted into the pipeline");
      @(posedge clk_i);
      #1;
    end
    fetch_v_i   = 1'b0;
    data_yumi_i = 1'b0;
    miss_yumi_i = 1'b0;
    fill_v_i    = 1'b0;
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic first_miss_after_reset();
    assert (!data_v_o && !miss_v_o && !fetch_yumi_o && !fill_yumi_o)
      else stop_with_error("handshake outputs were not low after reset");
    expect_miss_fill(32'h0000_1010, 1'b0);
  endtask

  // Word 1 of a way 0 block, word 0 of a way 1 block
  task automatic other_word_hits();
    expect_hit(32'h0000_1014);
    expect_miss_fill(32'h0000_1094, 1'b1);
    expect_hit(32'h0000_1090);
  endtask

  task automatic two_tags_one_set();
    expect_miss_fill(32'h0000_4048, 1'b0);
    expect_miss_fill(32'h0000_40c8, 1'b1);
    expect_hit(32'h0000_4048);
    expect_hit(32'h0000_40cc);
  endtask

  // Way 0 is touched last before the way 1 hit
  task automatic lru_replacement();
    expect_hit(32'h0000_1010);
    expect_miss_fill(32'h0000_1110, 1'b1);
    expect_hit(32'h0000_1014);
    expect_hit(32'h0000_1114);
    expect_miss_fill(32'h0000_1190, 1'b0);
  endtask

  task automatic stalled_output();
    addr_t cached[4];
    int    misses_before;
    cached[0]     = 32'h0000_1110;
    cached[1]     = 32'h0000_1114;
    cached[2]     = 32'h0000_1190;
    cached[3]     = 32'h0000_1194;
    misses_before = miss_seen;
    for (int i = 0; i < 16; i++)
    begin
      pending_q.push_back(cached[$urandom_range(3, 0)]);
    end
    stream_fetches(8);
    assert (miss_seen == misses_before)
      else stop_with_error("a block that should be cached missed under back-pressure");
  endtask

  // Three tags over eight sets force evictions
  task automatic random_stream();
    addr_t pool[48];
    for (int i = 0; i < 48; i++)
    begin
      pool[i] = 32'h0002_0000 + 32'((i / 16) * 128 + (i % 8) * 8 + ((i / 8) % 2) * 4);
    end
    for (int i = 0; i < 200; i++)
    begin
      pending_q.push_back(pool[$urandom_range(47, 0)]);
    end
    stream_fetches(2);
  endtask

  initial
  begin
    void'($urandom(32'hf215_f4e5));
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    fetch_v_i    = 1'b0;
    fetch_addr_i = '0;
    data_yumi_i  = 1'b0;
    miss_yumi_i  = 1'b0;
    fill_v_i     = 1'b0;
    fill_i       = '0;
    miss_seen    = 0;
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    first_miss_after_reset();
    other_word_hits();
    two_tags_one_set();
    lru_replacement();
    stalled_output();
    random_stream();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* source/icache_top.sv */
`timescale 1ns/1ps

module icache_top
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      fetch_v_i,
  input  addr_t     fetch_addr_i,
  output logic      fetch_yumi_o,
  output instr_t    data_o,
  output logic      data_v_o,
  input  logic      data_yumi_i,
  output miss_req_s miss_o,
  output logic      miss_v_o,
  input  logic      miss_yumi_i,
  input  logic      fill_v_i,
  input  fill_pkt_s fill_i,
  output logic      fill_yumi_o
);

  logic                  rd_v;
  index_t                rd_index;
  word_sel_t             rd_word;
  tag_t                  lookup_tag;
  way_vec_t              hit, valid;
  instr_t [num_ways-1:0] bank;
  index_t                lru_index;
  way_vec_t              lru_valid;
  logic                  touch_v;
  way_t                  touch_way, repl_way;

  icache_fetch_pipe u_pipe (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fetch_v_i    (fetch_v_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_yumi_o (fetch_yumi_o),
    .data_o       (data_o),
    .data_v_o     (data_v_o),
    .data_yumi_i  (data_yumi_i),
    .miss_o       (miss_o),
    .miss_v_o     (miss_v_o),
    .miss_yumi_i  (miss_yumi_i),
    .fill_v_i     (fill_v_i),
    .fill_yumi_o  (fill_yumi_o),
    .rd_v_o       (rd_v),
    .rd_index_o   (rd_index),
    .rd_word_o    (rd_word),
    .lookup_tag_o (lookup_tag),
    .hit_i        (hit),
    .valid_i      (valid),
    .bank_i       (bank),
    .lru_index_o  (lru_index),
    .lru_valid_o  (lru_valid),
    .touch_v_o    (touch_v),
    .touch_way_o  (touch_way),
    .repl_way_i   (repl_way)
  );

  // Arrays see only the accepted fill
  icache_tag_array u_tag (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .rd_v_i       (rd_v),
    .rd_index_i   (rd_index),
    .lookup_tag_i (lookup_tag),
    .fill_v_i     (fill_yumi_o),
    .fill_i       (fill_i),
    .hit_o        (hit),
    .valid_o      (valid)
  );

  icache_data_array u_data (
    .clk_i      (clk_i),
    .rd_v_i     (rd_v),
    .rd_index_i (rd_index),
    .rd_word_i  (rd_word),
    .fill_v_i   (fill_yumi_o),
    .fill_i     (fill_i),
    .bank_o     (bank)
  );

  icache_lru u_lru (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .index_i     (lru_index),
    .valid_i     (lru_valid),
    .touch_v_i   (touch_v),
    .touch_way_i (touch_way),
    .repl_way_o  (repl_way)
  );

endmodule

/* source/icache_fetch_pipe.sv */
`timescale 1ns/1ps

module icache_fetch_pipe
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  fetch_v_i,
  input  addr_t                 fetch_addr_i,
  output logic                  fetch_yumi_o,
  output instr_t                data_o,
  output logic                  data_v_o,
  input  logic                  data_yumi_i,
  output miss_req_s             miss_o,
  output logic                  miss_v_o,
  input  logic                  miss_yumi_i,
  input  logic                  fill_v_i,
  output logic                  fill_yumi_o,
  output logic                  rd_v_o,
  output index_t                rd_index_o,
  output word_sel_t             rd_word_o,
  output tag_t                  lookup_tag_o,
  input  way_vec_t              hit_i,
  input  way_vec_t              valid_i,
  input  instr_t [num_ways-1:0] bank_i,
  output index_t                lru_index_o,
  output way_vec_t              lru_valid_o,
  output logic                  touch_v_o,
  output way_t                  touch_way_o,
  input  way_t                  repl_way_i
);

  fetch_state_e state_r, state_n;
  logic         is_ready, is_miss, is_recover;

  tl_stage_s tl_r;
  tv_stage_s tv_r;
  logic      tl_v_r, tv_v_r;
  logic      tv_we, tv_deq;
  logic      tv_hit;
  way_t      tv_hit_way;

  assign is_ready   = (state_r == e_ready);
  assign is_miss    = (state_r == e_miss);
  assign is_recover = (state_r == e_recover);

  ////////////////////////////////////////
  // Accept and array read
  ////////////////////////////////////////

  assign tv_deq       = data_yumi_i | miss_yumi_i;
  assign tv_we        = tl_v_r & is_ready & (~tv_v_r | tv_deq);
  assign fetch_yumi_o = is_ready & fetch_v_i & (~tl_v_r | tv_we);

  // Recover re-reads the set of the request held in TL
  assign rd_v_o       = fetch_yumi_o | is_recover;
  assign rd_index_o   = is_recover ? tl_r.addr[block_offset_width +: index_width]
                                   : fetch_addr_i[block_offset_width +: index_width];
  assign rd_word_o    = is_recover ? tl_r.addr[byte_offset_width +: word_sel_width]
                                   : fetch_addr_i[byte_offset_width +: word_sel_width];
  assign lookup_tag_o = tl_r.addr[addr_width-1 -: tag_width];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tl_v_r <= 1'b0;
      tv_v_r <= 1'b0;
    end
    else
    begin
      tl_v_r <= fetch_yumi_o | (tl_v_r & ~tv_we);
      tv_v_r <= tv_we | (tv_v_r & ~tv_deq);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_yumi_o)
    begin
      tl_r <= '{addr: fetch_addr_i};
    end
    if (tv_we)
    begin
      tv_r <= '{addr: tl_r.addr, hit: hit_i, valid: valid_i, bank: bank_i};
    end
  end

  ////////////////////////////////////////
  // Tag verify
  ////////////////////////////////////////

  always_comb
  begin
    tv_hit_way = '0;
    for (int w = 0; w < num_ways; w++)
    begin
      if (tv_r.hit[w])
      begin
        tv_hit_way = way_t'(w);
      end
    end
  end

  assign tv_hit = |tv_r.hit;

  // Bank number is hit way plus word offset
  assign data_o = tv_r.bank[way_t'(tv_hit_way
                    + way_t'(tv_r.addr[byte_offset_width +: word_sel_width]))];

  assign data_v_o = is_ready & tv_v_r & tv_hit;
  assign miss_v_o = is_ready & tv_v_r & ~tv_hit;
  assign miss_o   = '{addr: {tv_r.addr[addr_width-1:block_offset_width],
                             {block_offset_width{1'b0}}},
                      repl_way: repl_way_i};

  assign lru_index_o = tv_r.addr[block_offset_width +: index_width];
  assign lru_valid_o = tv_r.valid;
  assign touch_v_o   = data_v_o & data_yumi_i;
  assign touch_way_o = tv_hit_way;

  assign fill_yumi_o = is_miss & fill_v_i;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_ready:
      begin
        if (miss_v_o && miss_yumi_i)
        begin
          state_n = e_miss;
        end
      end
      e_miss:
      begin
        if (fill_yumi_o)
        begin
          state_n = e_recover;
        end
      end
      default: state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_ready;
    end
    else
    begin
      state_r <= state_n;
    end
  end

endmodule

/* source/icache_lru.sv */
`timescale 1ns/1ps

module icache_lru
  import icache_cfg_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  index_t   index_i,
  input  way_vec_t valid_i,
  input  logic     touch_v_i,
  input  way_t     touch_way_i,
  output way_t     repl_way_o
);

  // Least recently used way of each set
  way_t [num_sets-1:0] lru_r;

  logic invalid_found;
  way_t invalid_way;

  // Lowest invalid way wins
  always_comb
  begin
    invalid_found = 1'b0;
    invalid_way   = '0;
    for (int w = num_ways - 1; w >= 0; w--)
    begin
      if (!valid_i[w])
      begin
        invalid_found = 1'b1;
        invalid_way   = way_t'(w);
      end
    end
  end

  assign repl_way_o = invalid_found ? invalid_way : lru_r[index_i];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      lru_r <= '0;
    end
    else if (touch_v_i)
    begin
      lru_r[index_i] <= ~touch_way_i;
    end
  end

endmodule

/* source/icache_data_array.sv */
`timescale 1ns/1ps

module icache_data_array
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rd_v_i,
  input  index_t                rd_index_i,
  input  word_sel_t             rd_word_i,
  input  logic                  fill_v_i,
  input  fill_pkt_s             fill_i,
  output instr_t [num_ways-1:0] bank_o
);

  ////////////////////////////////////////
  // Fill rotation
  ////////////////////////////////////////

  // Word w of way v lives in bank (w + v) mod 2
  instr_t [num_ways-1:0] fill_words;
  instr_t [num_ways-1:0] fill_rot;

  assign fill_words = fill_i.data;

  ////////////////////////////////////////
  // Banks
  ////////////////////////////////////////

  for (genvar b = 0; b < num_ways; b++)
  begin : g_bank
    instr_t    mem_r [num_sets][2**word_sel_width];
    instr_t    rd_data_r;
    word_sel_t fill_offset;

    // Offset inside the bank for the filled way
    assign fill_offset = word_sel_t'(way_t'(b) - fill_i.way);

    // Block rotated left by the way number
    assign fill_rot[b] = fill_words[fill_offset];

    always_ff @(posedge clk_i)
    begin
      if (fill_v_i)
      begin
        mem_r[fill_i.index][fill_offset] <= fill_rot[b];
      end
      if (rd_v_i)
      begin
        rd_data_r <= mem_r[rd_index_i][rd_word_i];
      end
    end

    // held until the next read
    assign bank_o[b] = rd_data_r;
  end

endmodule

/* source/icache_tag_array.sv */
`timescale 1ns/1ps

module icache_tag_array
  import icache_cfg_pkg::*;
  import icache_msg_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      rd_v_i,
  input  index_t    rd_index_i,
  input  tag_t      lookup_tag_i,
  input  logic      fill_v_i,
  input  fill_pkt_s fill_i,
  output way_vec_t  hit_o,
  output way_vec_t  valid_o
);

  tag_t [num_ways-1:0]     tag_mem_r [num_sets];
  way_vec_t [num_sets-1:0] valid_r;

  // Set captured by the last read
  tag_t [num_ways-1:0] rd_tag_r;
  way_vec_t            rd_valid_r;

  always_ff @(posedge clk_i)
  begin
    if (fill_v_i)
    begin
      tag_mem_r[fill_i.index][fill_i.way] <= fill_i.tag;
    end
    if (rd_v_i)
    begin
      rd_tag_r <= tag_mem_r[rd_index_i];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r    <= '0;
      rd_valid_r <= '0;
    end
    else
    begin
      if (fill_v_i)
      begin
        valid_r[fill_i.index][fill_i.way] <= 1'b1;
      end
      if (rd_v_i)
      begin
        rd_valid_r <= valid_r[rd_index_i];
      end
    end
  end

  // Compare against the tag now sitting in TL
  always_comb
  begin
    for (int w = 0; w < num_ways; w++)
    begin
      hit_o[w] = rd_valid_r[w] && (rd_tag_r[w] == lookup_tag_i);
    end
  end

  assign valid_o = rd_valid_r;

endmodule

/* source/icache_msg_pkg.sv */
package icache_msg_pkg;

  import icache_cfg_pkg::*;

  // Miss request to the fill engine
  typedef struct packed {
    addr_t addr;
    way_t  repl_way;
  } miss_req_s;

  // Whole block returned for a miss
  typedef struct packed {
    index_t index;
    way_t   way;
    tag_t   tag;
    block_t data;
  } fill_pkt_s;

  // Tag lookup stage
  typedef struct packed {
    addr_t addr;
  } tl_stage_s;

  // Tag verify stage, bank words are still raw
  typedef struct packed {
    addr_t                 addr;
    way_vec_t              hit;
    way_vec_t              valid;
    instr_t [num_ways-1:0] bank;
  } tv_stage_s;

  typedef enum logic [1:0] {
    e_ready,
    e_miss,
    e_recover
  } fetch_state_e;

endpackage

/* source/icache_cfg_pkg.sv */
package icache_cfg_pkg;

  // Cache geometry
  localparam int num_ways    = 2;
  localparam int num_sets    = 16;
  localparam int instr_width = 32;
  localparam int block_width = 64;

  // Address split is tag, index, word, byte
  localparam int addr_width         = 32;
  localparam int tag_width          = 25;
  localparam int index_width        = 4;
  localparam int word_sel_width     = 1;
  localparam int byte_offset_width  = 2;
  localparam int block_offset_width = 3;

  // Byte address, always physical
  typedef logic [addr_width-1:0] addr_t;

  // Address bits 31 to 7
  typedef logic [tag_width-1:0] tag_t;

  // Address bits 6 to 3
  typedef logic [index_width-1:0] index_t;

  // Address bit 2 picks the word inside a block
  typedef logic [word_sel_width-1:0] word_sel_t;

  // Way number and per-way flags
  typedef logic [$clog2(num_ways)-1:0] way_t;
  typedef logic [num_ways-1:0] way_vec_t;

  // One instruction is also one bank word
  typedef logic [instr_width-1:0] instr_t;

  // Word 0 sits in the low half
  typedef logic [block_width-1:0] block_t;

endpackage
